/* design/ld_pkg.sv */
// ----------------------------------------------------------------------
// shared definitions for the load unit
// covers address and data widths, the load operation encoding, the
// page offset union and the rule that maps an operation to its size
// code. design files import it inside the module body
// ----------------------------------------------------------------------
package ld_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    // sv39 virtual address and a 56 bit physical address
    localparam int unsigned VLEN             = 39;
    localparam int unsigned PLEN             = 56;
    localparam int unsigned XLEN             = 64;
    localparam int unsigned TRANS_ID_BITS    = 3;
    // a 4 KiB page gives the offset that also indexes the data cache
    localparam int unsigned PAGE_OFFSET_BITS = 12;
    localparam int unsigned TAG_BITS         = PLEN - PAGE_OFFSET_BITS;

    // ------------------------------------------------------------------
    // load operations
    // ------------------------------------------------------------------
    // the U forms zero-extend and the others sign-extend, LD needs neither
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWU,
        LD
    } ld_op_e;

    // the low part of the virtual address is read two ways
    // the cache index and the store check take the flat view
    // realignment takes the byte offset inside the 64 bit word
    typedef union packed {
        logic [PAGE_OFFSET_BITS-1:0] flat;
        struct packed {
            logic [8:0] word_idx;
            logic [2:0] byte_off;
        } part;
    } ld_vaddr_low_u;

    // size code of the cache transfer, the log2 of the operand bytes
    function automatic logic [1:0] transfer_size(input ld_op_e op);
        logic [1:0] size;
        unique case (op)
            LB, LBU: size = 2'd0;
            LH, LHU: size = 2'd1;
            LW, LWU: size = 2'd2;
            default: size = 2'd3;
        endcase
        return size;
    endfunction

endpackage

/* design/ld_capture_if.sv */
// ----------------------------------------------------------------------
// hand-over of an accepted load from the control FSM to the result stage
// the FSM drives every signal through the ctrl modport and the result
// stage samples them through the result modport
// ----------------------------------------------------------------------
`timescale 1ns/1ps

interface ld_capture_if;
    import ld_pkg::*;

    // one cycle strobe when the FSM accepts the load
    logic                     pop;
    // load fields, only meaningful while pop is high
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [2:0]               byte_offset;
    ld_op_e                   op;
    // the cache request is being killed in this cycle
    logic                     kill;
    // the FSM sits in its flush state
    logic                     flushing;

    modport ctrl (
        output pop, trans_id, byte_offset, op, kill, flushing
    );

    modport result (
        input pop, trans_id, byte_offset, op, kill, flushing
    );

endinterface

/* design/ld_ctrl_fsm.sv */
// ----------------------------------------------------------------------
// load control FSM
// sequences address translation, the data cache request and the tag
// cycle for one load at a time. a TLB miss at grant aborts and retries
// and a store with the same page offset delays the request. accepted
// loads are handed to the result stage through the capture interface
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ld_ctrl_fsm (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    // load request from the issue side
    input  logic                             valid_i,
    input  logic [ld_pkg::VLEN-1:0]          vaddr_i,
    input  ld_pkg::ld_op_e                   op_i,
    input  logic [ld_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    // store check and translator
    input  logic                             page_offset_matches_i,
    input  logic                             dtlb_hit_i,
    // data cache handshake
    input  logic                             data_gnt_i,
    output logic                             translation_req_o,
    output logic                             data_req_o,
    output logic                             tag_valid_o,
    output logic                             kill_req_o,
    output logic                             pop_ld_o,
    output logic [1:0]                       data_size_o,
    // accepted load towards the result stage
    ld_capture_if.ctrl                       cap
);
    import ld_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_e;

    state_e        state_d, state_q;
    // high when a fresh load may start this cycle
    logic          accept_new;
    ld_vaddr_low_u vaddr_low;

    assign vaddr_low   = vaddr_i[PAGE_OFFSET_BITS-1:0];
    assign data_size_o = transfer_size(op_i);

    // ------------------------------------------------------------------
    // next state and strobes
    // ------------------------------------------------------------------
    always_comb begin : p_ctrl
        state_d           = state_q;
        accept_new        = 1'b0;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        kill_req_o        = 1'b0;
        pop_ld_o          = 1'b0;

        unique case (state_q)
            IDLE: begin
                accept_new = valid_i;
            end
            // the tag of the granted load goes out and a new load may start
            SEND_TAG: begin
                tag_valid_o = 1'b1;
                state_d     = IDLE;
                accept_new  = valid_i;
            end
            // a pending store overlaps, request again once it has drained
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // hold the request and the translation until the cache grants
            WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req_o        = 1'b1;
            end
            // free the cache port so the page walker can fill the TLB
            ABORT: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end
            // kill whatever the cache still has in its tag stage
            WAIT_FLUSH: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // translation starts at once even before the store check resolves
        if (accept_new) begin
            translation_req_o = 1'b1;
            if (page_offset_matches_i) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                data_req_o = 1'b1;
                if (!data_gnt_i) begin
                    state_d = WAIT_GNT;
                end
            end
        end

        // a grant with a hit sends the tag next cycle, a miss aborts
        if (data_req_o && data_gnt_i) begin
            if (dtlb_hit_i) begin
                pop_ld_o = 1'b1;
                state_d  = SEND_TAG;
            end else begin
                state_d  = ABORT;
            end
        end

        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------
    // capture interface
    // ------------------------------------------------------------------
    assign cap.pop         = pop_ld_o;
    assign cap.trans_id    = trans_id_i;
    assign cap.byte_offset = vaddr_low.part.byte_off;
    assign cap.op          = op_i;
    assign cap.kill        = kill_req_o;
    assign cap.flushing    = (state_q == WAIT_FLUSH);

endmodule

/* design/ld_result_align.sv */
// ----------------------------------------------------------------------
// load result stage
// keeps the fields of the load that is in the cache pipeline, shifts the
// read data down to the byte offset and extends it to 64 bits. the sign
// bit position is registered on pop so only a mux remains on read data
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ld_result_align (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             data_rvalid_i,
    input  logic [ld_pkg::XLEN-1:0]          data_rdata_i,
    ld_capture_if.result                     cap,
    output logic                             valid_o,
    output logic [ld_pkg::TRANS_ID_BITS-1:0] trans_id_o,
    output logic [ld_pkg::XLEN-1:0]          result_o
);
    import ld_pkg::*;

    logic [TRANS_ID_BITS-1:0] trans_id_q;
    logic [2:0]               offset_q;
    ld_op_e                   op_q;
    // byte that holds the sign of the operand in the unshifted word
    logic [2:0]               idx_d, idx_q;
    logic                     signed_d, signed_q;
    logic [XLEN-1:0]          shifted;
    logic [7:0]               sign_bits;
    logic                     sign_bit;

    // top byte of the operand is offset plus operand bytes minus one
    assign idx_d    = cap.byte_offset + ((3'd1 << transfer_size(cap.op)) - 3'd1);
    assign signed_d = cap.op inside {LB, LH, LW};

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_regs
        if (!rst_ni) begin
            op_q     <= LD;
            idx_q    <= '0;
            signed_q <= 1'b0;
        end else if (cap.pop) begin
            op_q     <= cap.op;
            idx_q    <= idx_d;
            signed_q <= signed_d;
        end
    end

    always_ff @(posedge clk_i) begin : p_payload_regs
        if (cap.pop) begin
            trans_id_q <= cap.trans_id;
            offset_q   <= cap.byte_offset;
        end
    end

    // ------------------------------------------------------------------
    // realign and extend
    // ------------------------------------------------------------------
    assign shifted = data_rdata_i >> {offset_q, 3'b000};

    // the sign is picked from the raw word in parallel with the shifter
    for (genvar i = 0; i < 8; i++) begin : g_sign_bits
        assign sign_bits[i] = data_rdata_i[8*i+7];
    end

    // unsigned loads pull the extension to zero
    assign sign_bit = signed_q & sign_bits[idx_q];

    always_comb begin : p_result
        unique case (op_q)
            LW, LWU: result_o = {{32{sign_bit}}, shifted[31:0]};
            LH, LHU: result_o = {{48{sign_bit}}, shifted[15:0]};
            LB, LBU: result_o = {{56{sign_bit}}, shifted[7:0]};
            default: result_o = shifted;
        endcase
    end

    // a killed or flushed request must not retire
    assign valid_o    = data_rvalid_i & ~cap.kill & ~cap.flushing;
    assign trans_id_o = trans_id_q;

endmodule

/* design/load_unit.sv */
// ----------------------------------------------------------------------
// load side of the load/store unit
// connects the load control FSM and the result stage and exposes plain
// ports towards issue, the address translator, the store check and the
// data cache. the cache index comes from the virtual address and the
// tag from the translated physical address one cycle later
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module load_unit (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    // load request
    input  logic                                valid_i,
    input  logic [ld_pkg::VLEN-1:0]             vaddr_i,
    input  ld_pkg::ld_op_e                      op_i,
    input  logic [7:0]                          be_i,
    input  logic [ld_pkg::TRANS_ID_BITS-1:0]    trans_id_i,
    output logic                                pop_ld_o,
    // load result
    output logic                                valid_o,
    output logic [ld_pkg::TRANS_ID_BITS-1:0]    trans_id_o,
    output logic [ld_pkg::XLEN-1:0]             result_o,
    // address translator
    output logic                                translation_req_o,
    output logic [ld_pkg::VLEN-1:0]             vaddr_o,
    input  logic [ld_pkg::PLEN-1:0]             paddr_i,
    input  logic                                dtlb_hit_i,
    // store check
    output logic [ld_pkg::PAGE_OFFSET_BITS-1:0] page_offset_o,
    input  logic                                page_offset_matches_i,
    // data cache
    output logic                                data_req_o,
    input  logic                                data_gnt_i,
    output logic [ld_pkg::PAGE_OFFSET_BITS-1:0] address_index_o,
    output logic [ld_pkg::TAG_BITS-1:0]         address_tag_o,
    output logic [7:0]                          data_be_o,
    output logic [1:0]                          data_size_o,
    output logic                                kill_req_o,
    output logic                                tag_valid_o,
    input  logic                                data_rvalid_i,
    input  logic [ld_pkg::XLEN-1:0]             data_rdata_i
);
    import ld_pkg::*;

    ld_vaddr_low_u vaddr_low;

    ld_capture_if cap_if ();

    // the page offset doubles as the cache index
    assign vaddr_low       = vaddr_i[PAGE_OFFSET_BITS-1:0];
    assign vaddr_o         = vaddr_i;
    assign page_offset_o   = vaddr_low.flat;
    assign address_index_o = vaddr_low.flat;
    assign data_be_o       = be_i;
    // valid in the tag cycle, the translation is a cycle old by then
    assign address_tag_o   = paddr_i[PAGE_OFFSET_BITS +: TAG_BITS];

    ld_ctrl_fsm u_ctrl (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .vaddr_i               (vaddr_i),
        .op_i                  (op_i),
        .trans_id_i            (trans_id_i),
        .page_offset_matches_i (page_offset_matches_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .data_gnt_i            (data_gnt_i),
        .translation_req_o     (translation_req_o),
        .data_req_o            (data_req_o),
        .tag_valid_o           (tag_valid_o),
        .kill_req_o            (kill_req_o),
        .pop_ld_o              (pop_ld_o),
        .data_size_o           (data_size_o),
        .cap                   (cap_if.ctrl)
    );

    ld_result_align u_result (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_rvalid_i (data_rvalid_i),
        .data_rdata_i  (data_rdata_i),
        .cap           (cap_if.result),
        .valid_o       (valid_o),
        .trans_id_o    (trans_id_o),
        .result_o      (result_o)
    );

endmodule

/* dv/load_unit_props.sv */
// ----------------------------------------------------------------------
// concurrent checks on the load control FSM
// attached to every ld_ctrl_fsm instance through bind
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module load_unit_props (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 flush_i,
    input logic                 pop_i,
    input ld_pkg::ld_op_e       op_i,
    input logic [2:0]           byte_offset_i,
    input logic                 data_req_i,
    input logic                 data_gnt_i,
    input logic                 dtlb_hit_i,
    input logic                 tag_valid_i,
    input logic                 kill_req_i
);
    import ld_pkg::*;

    // a word access must stay inside the 64 bit word
    a_word_offset: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i && (op_i inside {LW, LWU}) |-> byte_offset_i < 3'd5)
        else $error("word load accepted with offset %0d", byte_offset_i);

    // same for half words
    a_half_offset: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i && (op_i inside {LH, LHU}) |-> byte_offset_i < 3'd7)
        else $error("half load accepted with offset %0d", byte_offset_i);

    // a granted hit sends its tag in the next cycle and is not killed
    a_tag_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_req_i && data_gnt_i && dtlb_hit_i && !flush_i |=> tag_valid_i && !kill_req_i)
        else $error("tag_valid_o missing one cycle after grant");

    // a granted miss is aborted with kill and tag together
    a_abort_after_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_req_i && data_gnt_i && !dtlb_hit_i |=> tag_valid_i && kill_req_i)
        else $error("abort missing after a TLB miss at grant");

endmodule

bind ld_ctrl_fsm load_unit_props u_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .pop_i         (pop_ld_o),
    .op_i          (op_i),
    .byte_offset_i (vaddr_i[2:0]),
    .data_req_i    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .dtlb_hit_i    (dtlb_hit_i),
    .tag_valid_i   (tag_valid_o),
    .kill_req_i    (kill_req_o)
);

/* dv/tb_load_unit.sv */
// ----------------------------------------------------------------------
// testbench for the load unit
// applies a table of loads with grant delays, TLB misses, store offset
// matches and flushes. a small cache model answers each tag with read
// data two cycles later and a monitor records every retired load
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_load_unit;
    import ld_pkg::*;

    localparam time CLK_PERIOD      = 40ns;
    localparam int  NUM_ROWS        = 14;
    localparam int  WATCHDOG_CYCLES = NUM_ROWS * 40;

    typedef struct packed {
        ld_op_e                   op;
        logic [2:0]               off;
        logic [TRANS_ID_BITS-1:0] id;
        int                       gnt_delay;
        int                       miss;
        int                       match;
        bit                       flush;
        bit                       rand_data;
        logic [XLEN-1:0]          rdata;
        logic [XLEN-1:0]          expected;
    } row_t;

    logic                        clk_i;
    logic                        rst_ni;
    logic                        flush_i;
    logic                        valid_i;
    logic [VLEN-1:0]             vaddr_i;
    ld_op_e                      op_i;
    logic [7:0]                  be_i;
    logic [TRANS_ID_BITS-1:0]    trans_id_i;
    logic                        pop_ld_o;
    logic                        valid_o;
    logic [TRANS_ID_BITS-1:0]    trans_id_o;
    logic [XLEN-1:0]             result_o;
    logic                        translation_req_o;
    logic [VLEN-1:0]             vaddr_o;
    logic [PLEN-1:0]             paddr_i;
    logic                        dtlb_hit_i;
    logic [PAGE_OFFSET_BITS-1:0] page_offset_o;
    logic                        page_offset_matches_i;
    logic                        data_req_o;
    logic                        data_gnt_i;
    logic [PAGE_OFFSET_BITS-1:0] address_index_o;
    logic [TAG_BITS-1:0]         address_tag_o;
    logic [7:0]                  data_be_o;
    logic [1:0]                  data_size_o;
    logic                        kill_req_o;
    logic                        tag_valid_o;
    logic                        data_rvalid_i;
    logic [XLEN-1:0]             data_rdata_i;

    row_t                        rows [NUM_ROWS];
    logic [63:0]                 seed = 64'd31158;
    logic [XLEN-1:0]             rsp_data;
    int                          rsp_cnt = 0;
    int                          valid_count = 0;
    int                          error_count = 0;
    logic [XLEN-1:0]             got_result;
    logic [TRANS_ID_BITS-1:0]    got_id;

    load_unit u_dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // cache model and retire monitor
    // ------------------------------------------------------------------
    // a tag without kill starts a response, any kill drops the pending one
    always @(negedge clk_i) begin : p_rsp_track
        if (tag_valid_o && !kill_req_o) begin
            rsp_cnt <= 2;
        end else if (kill_req_o) begin
            rsp_cnt <= 0;
        end else if (rsp_cnt > 0) begin
            rsp_cnt <= rsp_cnt - 1;
        end
    end

    always @(posedge clk_i) begin : p_rsp_drive
        #2;
        data_rvalid_i = (rsp_cnt == 1);
        data_rdata_i  = (rsp_cnt == 1) ? rsp_data : '0;
    end

    always @(negedge clk_i) begin : p_monitor
        if (valid_o) begin
            valid_count = valid_count + 1;
            got_result  = result_o;
            got_id      = trans_id_o;
        end
    end

    // ------------------------------------------------------------------
    // reference rules and checks
    // ------------------------------------------------------------------
    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // shift down by the byte offset, then extend by the operand width
    function automatic logic [XLEN-1:0] expected_load(input ld_op_e op, input logic [2:0] off,
                                                      input logic [XLEN-1:0] data);
        logic [XLEN-1:0] sh;
        sh = data >> (8 * off);
        case (op)
            LB:      return {{56{sh[7]}}, sh[7:0]};
            LBU:     return {56'd0, sh[7:0]};
            LH:      return {{48{sh[15]}}, sh[15:0]};
            LHU:     return {48'd0, sh[15:0]};
            LW:      return {{32{sh[31]}}, sh[31:0]};
            LWU:     return {32'd0, sh[31:0]};
            default: return sh;
        endcase
    endfunction

    // one enable bit per operand byte, starting at the byte offset
    function automatic logic [7:0] byte_mask(input ld_op_e op, input logic [2:0] off);
        logic [7:0] m;
        case (op)
            LB, LBU: m = 8'h01;
            LH, LHU: m = 8'h03;
            LW, LWU: m = 8'h0f;
            default: m = 8'hff;
        endcase
        return m << off;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_result(input string what, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("[ERROR] %0t: %s got %h expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_id(input logic [TRANS_ID_BITS-1:0] got,
                            input logic [TRANS_ID_BITS-1:0] exp);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("[ERROR] %0t: trans_id_o got %0d expected %0d",
                                        $time, got, exp));
        end
    endtask

    // byte, half, word and double map to size codes 0 to 3
    task automatic check_size(input ld_op_e op, input logic [1:0] got);
        logic [1:0] exp;
        case (op)
            LB, LBU: exp = 2'd0;
            LH, LHU: exp = 2'd1;
            LW, LWU: exp = 2'd2;
            default: exp = 2'd3;
        endcase
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("[ERROR] %0t: data_size_o for %s got %0d expected %0d",
                                        $time, op.name(), got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("[ERROR] %0t: %s got %b expected %b",
                                        $time, what, got, exp));
        end
    endtask

    // ------------------------------------------------------------------
    // one table row
    // ------------------------------------------------------------------
    task automatic run_row(input int i);
        row_t            r;
        int              match_left;
        int              gnt_left;
        int              miss_left;
        int              req_cycles;
        int              start_count;
        bit              done;
        bit              expect_abort;
        logic [XLEN-1:0] exp;
        logic [VLEN-1:0] addr;
        r            = rows[i];
        match_left   = r.match;
        gnt_left     = r.gnt_delay;
        miss_left    = r.miss;
        req_cycles   = 0;
        done         = 0;
        expect_abort = 0;
        addr         = {27'h1a5, 9'(i), r.off};
        if (r.rand_data) begin
            seed     = xorshift(seed);
            rsp_data = seed;
        end else begin
            rsp_data = r.rdata;
        end
        exp         = r.rand_data ? expected_load(r.op, r.off, rsp_data) : r.expected;
        start_count = valid_count;
        // request phase, one iteration per clock until the load pops
        while (!done) begin
            @(posedge clk_i);
            #2;
            valid_i               = 1'b1;
            vaddr_i               = addr;
            op_i                  = r.op;
            be_i                  = byte_mask(r.op, r.off);
            trans_id_i            = r.id;
            paddr_i               = {44'(i + 1), 12'h0};
            page_offset_matches_i = (match_left > 0);
            dtlb_hit_i            = (miss_left == 0);
            data_gnt_i            = (gnt_left == 0);
            @(negedge clk_i);
            if (expect_abort) begin
                check_flag("kill_req_o on abort", kill_req_o, 1'b1);
                check_flag("tag_valid_o on abort", tag_valid_o, 1'b1);
                expect_abort = 0;
            end
            if (page_offset_matches_i) begin
                check_flag("data_req_o during page match", data_req_o, 1'b0);
                match_left--;
            end else if (data_req_o) begin
                req_cycles++;
                if (data_gnt_i && !dtlb_hit_i) begin
                    check_flag("pop_ld_o on TLB miss", pop_ld_o, 1'b0);
                    expect_abort = 1;
                end else if (data_gnt_i) begin
                    check_flag("pop_ld_o on grant", pop_ld_o, 1'b1);
                    check_size(r.op, data_size_o);
                    check_result("vaddr_o", XLEN'(vaddr_o), XLEN'(addr));
                    check_result("page_offset_o", XLEN'(page_offset_o),
                                 XLEN'(addr[PAGE_OFFSET_BITS-1:0]));
                    check_result("address_index_o", XLEN'(address_index_o),
                                 XLEN'(addr[PAGE_OFFSET_BITS-1:0]));
                    check_result("data_be_o", XLEN'(data_be_o),
                                 XLEN'(byte_mask(r.op, r.off)));
                    done = 1;
                end else begin
                    gnt_left--;
                end
            end else if (translation_req_o && !dtlb_hit_i) begin
                miss_left--;
            end
        end
        if (r.miss == 0) begin
            check_flag("data_req_o held for grant delay plus one",
                       req_cycles == r.gnt_delay + 1, 1'b1);
        end
        // tag cycle
        @(posedge clk_i);
        #2;
        valid_i               = 1'b0;
        data_gnt_i            = 1'b0;
        page_offset_matches_i = 1'b0;
        dtlb_hit_i            = 1'b1;
        @(negedge clk_i);
        check_flag("tag_valid_o after grant", tag_valid_o, 1'b1);
        check_flag("kill_req_o in tag cycle", kill_req_o, 1'b0);
        check_result("address_tag_o", XLEN'(address_tag_o), XLEN'(i + 1));
        if (r.flush) begin
            // the flush lands so that the read data returns in the flush cycle
            @(posedge clk_i);
            #2;
            flush_i = 1'b1;
            @(posedge clk_i);
            #2;
            flush_i = 1'b0;
            @(negedge clk_i);
            check_flag("kill_req_o on flush", kill_req_o, 1'b1);
            check_flag("tag_valid_o on flush", tag_valid_o, 1'b1);
            check_flag("valid_o on read data during flush", valid_o, 1'b0);
            repeat (4) @(negedge clk_i);
            check_flag("no valid_o for a flushed load", valid_count == start_count, 1'b1);
        end else begin
            wait (valid_count != start_count);
            check_result($sformatf("result_o of %s", r.op.name()), got_result, exp);
            check_id(got_id, r.id);
            @(negedge clk_i);
            check_flag("one valid_o per load", valid_count == start_count + 1, 1'b1);
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin : p_watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("timeout: the load unit stopped making progress");
    end

    initial begin : p_main
        clk_i                 = 1'b0;
        rst_ni                = 1'b0;
        flush_i               = 1'b0;
        valid_i               = 1'b0;
        vaddr_i               = '0;
        op_i                  = LD;
        be_i                  = 8'hff;
        trans_id_i            = '0;
        paddr_i               = '0;
        dtlb_hit_i            = 1'b1;
        page_offset_matches_i = 1'b0;
        data_gnt_i            = 1'b0;
        data_rvalid_i         = 1'b0;
        data_rdata_i          = '0;
        rsp_data              = '0;

        // op, offset, id, gnt delay, miss, match, flush, random, data, expected
        rows[0]  = '{LB,  3'd3, 3'd1, 0, 0, 0, 0, 0, 64'h1122_3344_8566_7788,
                     64'hffff_ffff_ffff_ff85};
        rows[1]  = '{LBU, 3'd3, 3'd2, 0, 0, 0, 0, 0, 64'h1122_3344_8566_7788,
                     64'h0000_0000_0000_0085};
        rows[2]  = '{LH,  3'd2, 3'd3, 0, 0, 0, 0, 0, 64'h0000_0000_f00d_0000,
                     64'hffff_ffff_ffff_f00d};
        rows[3]  = '{LHU, 3'd6, 3'd4, 0, 0, 0, 0, 0, 64'hbeef_0000_0000_0000,
                     64'h0000_0000_0000_beef};
        rows[4]  = '{LW,  3'd4, 3'd5, 0, 0, 0, 0, 0, 64'h8765_4321_0000_0000,
                     64'hffff_ffff_8765_4321};
        rows[5]  = '{LWU, 3'd0, 3'd6, 0, 0, 0, 0, 0, 64'hffff_ffff_9abc_def0,
                     64'h0000_0000_9abc_def0};
        rows[6]  = '{LD,  3'd0, 3'd7, 0, 0, 0, 0, 0, 64'h0123_4567_89ab_cdef,
                     64'h0123_4567_89ab_cdef};
        rows[7]  = '{LW,  3'd0, 3'd0, 3, 0, 0, 0, 0, 64'h0000_0000_7fff_ffff,
                     64'h0000_0000_7fff_ffff};
        rows[8]  = '{LH,  3'd0, 3'd1, 0, 2, 0, 0, 0, 64'h0000_0000_0000_8001,
                     64'hffff_ffff_ffff_8001};
        rows[9]  = '{LBU, 3'd7, 3'd2, 0, 0, 3, 0, 0, 64'ha500_0000_0000_0000,
                     64'h0000_0000_0000_00a5};
        rows[10] = '{LD,  3'd0, 3'd3, 0, 0, 0, 1, 0, 64'h0, 64'h0};
        rows[11] = '{LB,  3'd5, 3'd4, 1, 0, 0, 0, 1, 64'h0, 64'h0};
        rows[12] = '{LWU, 3'd4, 3'd5, 2, 1, 0, 0, 1, 64'h0, 64'h0};
        rows[13] = '{LH,  3'd6, 3'd6, 0, 0, 1, 0, 1, 64'h0, 64'h0};

        repeat (4) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_flag("pop_ld_o after reset", pop_ld_o, 1'b0);
        check_flag("data_req_o after reset", data_req_o, 1'b0);
        check_flag("tag_valid_o after reset", tag_valid_o, 1'b0);
        check_flag("kill_req_o after reset", kill_req_o, 1'b0);
        check_flag("translation_req_o after reset", translation_req_o, 1'b0);
        check_flag("valid_o after reset", valid_o, 1'b0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* src.f */
design/ld_pkg.sv
design/ld_capture_if.sv
design/ld_ctrl_fsm.sv
design/ld_result_align.sv
design/load_unit.sv
dv/load_unit_props.sv
dv/tb_load_unit.sv

/* Bender.yml */
package:
  name: load_unit

sources:
  - design/ld_pkg.sv
  - design/ld_capture_if.sv
  - design/ld_ctrl_fsm.sv
  - design/ld_result_align.sv
  - design/load_unit.sv
  - target: simulation
    files:
      - dv/load_unit_props.sv
      - dv/tb_load_unit.sv
